// ==== files.f ====
rtl/mips_isa_pkg.sv
rtl/ex_stage_pkg.sv
rtl/ex_operand_select.sv
rtl/alu_decoder.sv
rtl/alu.sv
rtl/ex_mem_register.sv
rtl/execute_stage.sv
tb/execute_stage_checker.sv
tb/tb_execute_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module tb_execute_stage \
	-Mdir obj_dir -o sim_execute_stage > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_execute_stage +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0

// ==== tb/tb_execute_stage.sv ====
`default_nettype none

module tb_execute_stage;

	timeunit 1ns;
	timeprecision 1ps;

	import mips_isa_pkg::*;
	import ex_stage_pkg::*;

	localparam int RESET_CYCLES = 3;
	localparam int NUM_DIRECTED = 20;
	localparam int NUM_RANDOM   = 400;
	// every record takes one cycle, plus reset and a margin for draining
	localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_DIRECTED + NUM_RANDOM + 64;
	localparam logic [31:0] SEED = 32'h01678c66;

	logic    clk;
	logic    rst_n;
	id_ex_t  id_ex;
	ex_mem_t ex_mem;

	execute_stage execute_stage_i (
		.i_clk    (clk),
		.i_rst_n  (rst_n),
		.i_id_ex  (id_ex),
		.o_ex_mem (ex_mem)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ==========================================================
	// reference model
	// ==========================================================
	function automatic ex_mem_t expected_ex_mem(input id_ex_t r);
		ex_mem_t     e;
		logic [31:0] b;
		logic [31:0] res;
		b = r.ex.alusrc ? r.imm : r.rt_data;
		case (r.ex.alu_op)
			ALU_OP_ADD: res = r.rs_data + b;
			ALU_OP_SUB: res = r.rs_data - b;
			ALU_OP_OR:  res = r.rs_data | b;
			default: begin
				// r-type, funct in imm[5:0], shamt in imm[10:6]
				case (r.imm[5:0])
					FUNCT_SUB: res = r.rs_data - b;
					FUNCT_AND: res = r.rs_data & b;
					FUNCT_OR:  res = r.rs_data | b;
					FUNCT_NOR: res = ~(r.rs_data | b);
					FUNCT_SLT: res = ($signed(r.rs_data) < $signed(b)) ? 32'd1 : 32'd0;
					FUNCT_SLL: res = b << r.imm[10:6];
					FUNCT_SRL: res = b >> r.imm[10:6];
					default:   res = r.rs_data + b;
				endcase
			end
		endcase
		e.mem           = r.mem;
		e.wb            = r.wb;
		e.branch_target = r.next_pc + (r.imm << 2);
		e.zero          = (res == '0);
		e.alu_result    = res;
		e.rt_data       = r.rt_data;
		e.write_addr    = r.ex.regdst ? r.rd_addr : r.rt_addr;
		return e;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s expected %h, actual %h", $time, name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1, "compare failed on %s", name);
		end
	endtask

	// ==========================================================
	// stimulus helpers
	// ==========================================================
	function automatic id_ex_t build_record(input alu_op_e op, input logic alusrc,
			input logic regdst, input logic [15:0] imm16, input logic [31:0] rs,
			input logic [31:0] rt);
		id_ex_t r;
		r.ex.regdst = regdst;
		r.ex.alusrc = alusrc;
		r.ex.alu_op = op;
		r.mem       = 3'($urandom_range(0, 7));
		r.wb        = 2'($urandom_range(0, 3));
		r.next_pc   = $urandom() & 32'hffff_fffc;
		r.rs_data   = rs;
		r.rt_data   = rt;
		r.imm       = {{16{imm16[15]}}, imm16};
		r.rt_addr   = 5'($urandom_range(0, 31));
		// rd sits in the top bits of the immediate field
		r.rd_addr   = imm16[15:11];
		return r;
	endfunction

	task automatic drive_record(input id_ex_t rec);
		@(posedge clk);
		#1;
		id_ex = rec;
	endtask

	task automatic send_rtype(input logic [5:0] funct, input logic [4:0] shamt,
			input logic [31:0] rs, input logic [31:0] rt);
		logic [15:0] imm16;
		imm16 = {5'($urandom_range(0, 31)), shamt, funct};
		drive_record(build_record(ALU_OP_RTYPE, 1'b0, 1'b1, imm16, rs, rt));
	endtask

	task automatic send_class(input alu_op_e op, input logic alusrc, input logic [15:0] imm16,
			input logic [31:0] rs, input logic [31:0] rt);
		drive_record(build_record(op, alusrc, 1'b0, imm16, rs, rt));
	endtask

	// ==========================================================
	// compare and timeout
	// ==========================================================
	initial begin : compare
		ex_mem_t expected;
		forever begin
			@(posedge clk);
			// record captured at this edge, or the reset value
			if (rst_n) begin
				expected = expected_ex_mem(id_ex);
			end else begin
				expected = '0;
			end
			@(negedge clk);
			check_value("mem ctrl", 32'(expected.mem), 32'(ex_mem.mem));
			check_value("wb ctrl", 32'(expected.wb), 32'(ex_mem.wb));
			check_value("branch_target", expected.branch_target, ex_mem.branch_target);
			check_value("zero", 32'(expected.zero), 32'(ex_mem.zero));
			check_value("alu_result", expected.alu_result, ex_mem.alu_result);
			check_value("rt_data", expected.rt_data, ex_mem.rt_data);
			check_value("write_addr", 32'(expected.write_addr), 32'(ex_mem.write_addr));
			// bound assertions were evaluated at the rising edge before
			if (execute_stage_i.execute_stage_checker_i.failure_count != 0) begin
				$display("Assertion in execute_stage_checker failed before %0t", $time);
				$display("ERRORS FOUND");
				$fatal(1, "assertion failure");
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: test did not complete within %0d clock cycles", CYCLE_LIMIT);
		$display("ERRORS FOUND");
		$fatal(1, "timeout");
	end

	// ==========================================================
	// directed and random records
	// ==========================================================
	initial begin : stimulus
		logic [5:0]  known_funct [8];
		logic [5:0]  funct;
		logic [15:0] imm16;
		logic [31:0] rs;
		logic [31:0] rt;
		logic        alusrc;
		logic        regdst;
		alu_op_e     op;
		void'($urandom(SEED));
		known_funct = '{FUNCT_ADD, FUNCT_SUB, FUNCT_AND, FUNCT_OR,
			FUNCT_NOR, FUNCT_SLT, FUNCT_SLL, FUNCT_SRL};
		rst_n = 1'b0;
		id_ex = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// r-type arithmetic, logic and signed compare
		send_rtype(FUNCT_ADD, 5'd0, 32'd5, 32'd7);
		send_rtype(FUNCT_SUB, 5'd3, 32'd7, 32'd5);
		send_rtype(FUNCT_AND, 5'd0, 32'hf0f0_1234, 32'h0ff0_ffff);
		send_rtype(FUNCT_OR, 5'd0, 32'hf0f0_1234, 32'h0ff0_0001);
		send_rtype(FUNCT_NOR, 5'd0, 32'hf0f0_1234, 32'h0ff0_0001);
		send_rtype(FUNCT_SLT, 5'd0, 32'hffff_fffd, 32'd2);
		send_rtype(FUNCT_SLT, 5'd0, 32'd2, 32'hffff_fffd);
		send_rtype(FUNCT_SLT, 5'd0, 32'h8000_0000, 32'h8000_0000);
		// unknown funct falls back to add
		send_rtype(6'h3f, 5'd9, 32'h1234_5678, 32'h1111_1111);
		// shifts use rt and ignore rs
		send_rtype(FUNCT_SLL, 5'd4, 32'hdead_beef, 32'h0000_00f1);
		send_rtype(FUNCT_SRL, 5'd31, 32'hdead_beef, 32'h8000_0000);
		send_rtype(FUNCT_SLL, 5'd0, 32'h0, 32'h8765_4321);
		send_rtype(FUNCT_SUB, 5'd0, 32'h55, 32'h55);
		// classes ignore funct, imm replaces rt with alusrc
		send_class(ALU_OP_ADD, 1'b1, 16'hfffc, 32'h0000_1000, 32'hcafe_f00d);
		send_class(ALU_OP_ADD, 1'b1, 16'h7ff0, 32'h2000_0000, 32'h0000_0bad);
		send_class(ALU_OP_ADD, 1'b0, 16'h0022, 32'd10, 32'd20);
		send_class(ALU_OP_SUB, 1'b0, 16'hfff0, 32'h77, 32'h77);
		send_class(ALU_OP_SUB, 1'b0, 16'h0010, 32'h77, 32'h78);
		send_class(ALU_OP_OR, 1'b1, 16'h00ff, 32'h1200_0000, 32'hffff_ffff);
		send_class(ALU_OP_OR, 1'b1, 16'h8025, 32'h0000_0001, 32'h0);

		// back to back random records
		for (int n = 0; n < NUM_RANDOM; n++) begin
			op = alu_op_e'(2'($urandom_range(0, 3)));
			if ($urandom_range(0, 7) == 0) begin
				funct = 6'($urandom_range(0, 63));
			end else begin
				funct = known_funct[3'($urandom_range(0, 7))];
			end
			imm16  = {5'($urandom_range(0, 31)), 5'($urandom_range(0, 31)), funct};
			rs     = $urandom();
			rt     = ($urandom_range(0, 7) == 0) ? rs : $urandom();
			alusrc = 1'($urandom_range(0, 1));
			regdst = 1'($urandom_range(0, 1));
			drive_record(build_record(op, alusrc, regdst, imm16, rs, rt));
		end

		// last record is compared at the falling edge after its capture
		@(posedge clk);
		@(negedge clk);
		#1;
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/execute_stage_checker.sv ====
`default_nettype none

module execute_stage_checker (
	input logic                  i_clk,
	input logic                  i_rst_n,
	input ex_stage_pkg::id_ex_t  i_id_ex,
	input ex_stage_pkg::ex_mem_t i_ex_mem
);

	timeunit 1ns;
	timeprecision 1ps;

	import mips_isa_pkg::*;

	// incremented by every failing assertion
	int unsigned failure_count = 0;

	logic [REG_ADDR_W-1:0] selected_addr;

	// destination register as the input record selects it
	assign selected_addr = i_id_ex.ex.regdst ? i_id_ex.rd_addr : i_id_ex.rt_addr;

	// ==========================================================
	// EX/MEM record properties
	// ==========================================================
	controls_cleared_in_reset: assert property (
		@(posedge i_clk) !i_rst_n |-> (i_ex_mem.mem == '0) && (i_ex_mem.wb == '0)
	) else begin
		$error("EX/MEM control bits active during reset");
		failure_count++;
	end

	zero_matches_result: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		$past(i_rst_n) |-> i_ex_mem.zero == (i_ex_mem.alu_result == '0)
	) else begin
		$error("registered zero flag disagrees with registered result");
		failure_count++;
	end

	write_addr_follows_regdst: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		$past(i_rst_n) |-> i_ex_mem.write_addr == $past(selected_addr)
	) else begin
		$error("registered write_addr is not the selected rd or rt");
		failure_count++;
	end

endmodule

bind execute_stage execute_stage_checker execute_stage_checker_i (
	.i_clk    (i_clk),
	.i_rst_n  (i_rst_n),
	.i_id_ex  (i_id_ex),
	.i_ex_mem (o_ex_mem)
);

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`default_nettype none

module execute_stage (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  ex_stage_pkg::id_ex_t  i_id_ex,
	output ex_stage_pkg::ex_mem_t o_ex_mem
);

	import mips_isa_pkg::*;
	import ex_stage_pkg::*;

	ex_operands_t      operands;
	alu_ctrl_e         alu_ctrl;
	logic [DATA_W-1:0] alu_result;

	// ==========================================================
	// input side
	// ==========================================================
	ex_operand_select ex_operand_select_i (
		.i_id_ex    (i_id_ex),
		.o_operands (operands)
	);

	// ==========================================================
	// processing
	// ==========================================================
	alu_decoder alu_decoder_i (
		.i_alu_op   (i_id_ex.ex.alu_op),
		.i_funct    (operands.funct),
		.o_alu_ctrl (alu_ctrl)
	);

	alu alu_i (
		.i_operand_a (operands.operand_a),
		.i_operand_b (operands.operand_b),
		.i_shamt     (operands.shamt),
		.i_alu_ctrl  (alu_ctrl),
		.o_result    (alu_result)
	);

	// ==========================================================
	// output side
	// ==========================================================
	ex_mem_register ex_mem_register_i (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_operands   (operands),
		.i_alu_result (alu_result),
		.o_ex_mem     (o_ex_mem)
	);

endmodule

`default_nettype wire

// ==== rtl/ex_mem_register.sv ====
`default_nettype none

module ex_mem_register (
	input  logic                            i_clk,
	input  logic                            i_rst_n,
	input  ex_stage_pkg::ex_operands_t      i_operands,
	input  logic [mips_isa_pkg::DATA_W-1:0] i_alu_result,
	output ex_stage_pkg::ex_mem_t           o_ex_mem
);

	import ex_stage_pkg::*;

	ex_mem_t ex_mem_d;

	// ==========================================================
	// next record
	// ==========================================================
	always_comb begin
		ex_mem_d.mem           = i_operands.mem;
		ex_mem_d.wb            = i_operands.wb;
		ex_mem_d.branch_target = i_operands.branch_target;
		// zero flag feeds the beq decision in MEM
		ex_mem_d.zero          = (i_alu_result == '0);
		ex_mem_d.alu_result    = i_alu_result;
		ex_mem_d.rt_data       = i_operands.rt_data;
		ex_mem_d.write_addr    = i_operands.write_addr;
	end

	// ==========================================================
	// EX/MEM pipeline register
	// ==========================================================
	// loads every edge, no stall path
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ex_mem <= '0;
		end else begin
			o_ex_mem <= ex_mem_d;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`default_nettype none

module alu (
	input  logic [mips_isa_pkg::DATA_W-1:0]  i_operand_a,
	input  logic [mips_isa_pkg::DATA_W-1:0]  i_operand_b,
	input  logic [mips_isa_pkg::SHAMT_W-1:0] i_shamt,
	input  mips_isa_pkg::alu_ctrl_e          i_alu_ctrl,
	output logic [mips_isa_pkg::DATA_W-1:0]  o_result
);

	import mips_isa_pkg::*;

	logic [DATA_W-1:0] sum;
	logic [DATA_W-1:0] diff;
	logic              less;

	// ==========================================================
	// shared arithmetic
	// ==========================================================
	assign sum  = i_operand_a + i_operand_b;
	assign diff = i_operand_a - i_operand_b;

	// signed compare for slt
	assign less = $signed(i_operand_a) < $signed(i_operand_b);

	// ==========================================================
	// result select
	// ==========================================================
	always_comb begin
		case (i_alu_ctrl)
			ALU_AND: o_result = i_operand_a & i_operand_b;
			ALU_OR:  o_result = i_operand_a | i_operand_b;
			ALU_NOR: o_result = ~(i_operand_a | i_operand_b);
			ALU_ADD: o_result = sum;
			ALU_SUB: o_result = diff;
			ALU_SLT: o_result = {{(DATA_W-1){1'b0}}, less};
			// shifts act on operand b, rs is ignored
			ALU_SLL: o_result = i_operand_b << i_shamt;
			ALU_SRL: o_result = i_operand_b >> i_shamt;
			default: o_result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/alu_decoder.sv ====
`default_nettype none

module alu_decoder (
	input  mips_isa_pkg::alu_op_e              i_alu_op,
	input  logic [mips_isa_pkg::FUNCT_W-1:0]   i_funct,
	output mips_isa_pkg::alu_ctrl_e            o_alu_ctrl
);

	import mips_isa_pkg::*;

	alu_ctrl_e rtype_ctrl;

	// r-type function field
	always_comb begin
		case (i_funct)
			FUNCT_ADD: rtype_ctrl = ALU_ADD;
			FUNCT_SUB: rtype_ctrl = ALU_SUB;
			FUNCT_AND: rtype_ctrl = ALU_AND;
			FUNCT_OR:  rtype_ctrl = ALU_OR;
			FUNCT_NOR: rtype_ctrl = ALU_NOR;
			FUNCT_SLT: rtype_ctrl = ALU_SLT;
			FUNCT_SLL: rtype_ctrl = ALU_SLL;
			FUNCT_SRL: rtype_ctrl = ALU_SRL;
			// undefined funct still gives a defined sum
			default:   rtype_ctrl = ALU_ADD;
		endcase
	end

	// class from the main decoder overrides funct except for r-type
	always_comb begin
		case (i_alu_op)
			ALU_OP_ADD:   o_alu_ctrl = ALU_ADD;
			ALU_OP_SUB:   o_alu_ctrl = ALU_SUB;
			ALU_OP_OR:    o_alu_ctrl = ALU_OR;
			ALU_OP_RTYPE: o_alu_ctrl = rtype_ctrl;
			default:      o_alu_ctrl = ALU_ADD;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/ex_operand_select.sv ====
`default_nettype none

module ex_operand_select (
	input  ex_stage_pkg::id_ex_t       i_id_ex,
	output ex_stage_pkg::ex_operands_t o_operands
);

	import mips_isa_pkg::*;

	logic [DATA_W-1:0] imm_shifted;

	// word offset to byte offset
	assign imm_shifted = {i_id_ex.imm[DATA_W-3:0], 2'b00};

	always_comb begin
		// ==========================================================
		// alu operands
		// ==========================================================
		o_operands.operand_a = i_id_ex.rs_data;
		if (i_id_ex.ex.alusrc) begin
			o_operands.operand_b = i_id_ex.imm;
		end else begin
			o_operands.operand_b = i_id_ex.rt_data;
		end

		// funct and shamt sit in the low bits of the immediate field
		o_operands.funct = i_id_ex.imm[FUNCT_W-1:0];
		o_operands.shamt = i_id_ex.imm[FUNCT_W+SHAMT_W-1:FUNCT_W];

		// ==========================================================
		// branch target and destination register
		// ==========================================================
		o_operands.branch_target = i_id_ex.next_pc + imm_shifted;

		// rd for r-type, rt for i-type
		if (i_id_ex.ex.regdst) begin
			o_operands.write_addr = i_id_ex.rd_addr;
		end else begin
			o_operands.write_addr = i_id_ex.rt_addr;
		end

		// store data and later-stage controls pass straight on
		o_operands.rt_data = i_id_ex.rt_data;
		o_operands.mem     = i_id_ex.mem;
		o_operands.wb      = i_id_ex.wb;
	end

endmodule

`default_nettype wire

// ==== rtl/ex_stage_pkg.sv ====
`default_nettype none

package ex_stage_pkg;

	import mips_isa_pkg::*;

	// control groups, split by the stage that uses them
	typedef struct packed {
		logic    regdst;
		logic    alusrc;
		alu_op_e alu_op;
	} ex_ctrl_t;

	typedef struct packed {
		logic branch;
		logic memread;
		logic memwrite;
	} mem_ctrl_t;

	typedef struct packed {
		logic regwrite;
		logic memtoreg;
	} wb_ctrl_t;

	// ID/EX pipeline record
	typedef struct packed {
		ex_ctrl_t              ex;
		mem_ctrl_t             mem;
		wb_ctrl_t              wb;
		logic [DATA_W-1:0]     next_pc;
		logic [DATA_W-1:0]     rs_data;
		logic [DATA_W-1:0]     rt_data;
		logic [DATA_W-1:0]     imm;
		logic [REG_ADDR_W-1:0] rt_addr;
		logic [REG_ADDR_W-1:0] rd_addr;
	} id_ex_t;

	// selected operands, internal to the stage
	typedef struct packed {
		logic [DATA_W-1:0]     operand_a;
		logic [DATA_W-1:0]     operand_b;
		logic [SHAMT_W-1:0]    shamt;
		logic [FUNCT_W-1:0]    funct;
		logic [DATA_W-1:0]     branch_target;
		logic [REG_ADDR_W-1:0] write_addr;
		logic [DATA_W-1:0]     rt_data;
		mem_ctrl_t             mem;
		wb_ctrl_t              wb;
	} ex_operands_t;

	// EX/MEM pipeline record
	typedef struct packed {
		mem_ctrl_t             mem;
		wb_ctrl_t              wb;
		logic [DATA_W-1:0]     branch_target;
		logic                  zero;
		logic [DATA_W-1:0]     alu_result;
		logic [DATA_W-1:0]     rt_data;
		logic [REG_ADDR_W-1:0] write_addr;
	} ex_mem_t;

endpackage

`default_nettype wire

// ==== rtl/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

	// ==========================================================
	// datapath widths
	// ==========================================================
	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int FUNCT_W    = 6;
	localparam int SHAMT_W    = 5;

	// ==========================================================
	// r-type funct codes
	// ==========================================================
	localparam logic [FUNCT_W-1:0] FUNCT_SLL = 6'h00;
	localparam logic [FUNCT_W-1:0] FUNCT_SRL = 6'h02;
	localparam logic [FUNCT_W-1:0] FUNCT_ADD = 6'h20;
	localparam logic [FUNCT_W-1:0] FUNCT_SUB = 6'h22;
	localparam logic [FUNCT_W-1:0] FUNCT_AND = 6'h24;
	localparam logic [FUNCT_W-1:0] FUNCT_OR  = 6'h25;
	localparam logic [FUNCT_W-1:0] FUNCT_NOR = 6'h27;
	localparam logic [FUNCT_W-1:0] FUNCT_SLT = 6'h2a;

	// ==========================================================
	// alu operation class and alu control
	// ==========================================================
	// class comes from the main decoder in ID
	typedef enum logic [1:0] {
		ALU_OP_ADD   = 2'b00,
		ALU_OP_SUB   = 2'b01,
		ALU_OP_RTYPE = 2'b10,
		ALU_OP_OR    = 2'b11
	} alu_op_e;

	// classic mips alu control encoding, shifts in spare codes
	typedef enum logic [3:0] {
		ALU_AND = 4'b0000,
		ALU_OR  = 4'b0001,
		ALU_ADD = 4'b0010,
		ALU_SLL = 4'b0011,
		ALU_SRL = 4'b0100,
		ALU_SUB = 4'b0110,
		ALU_SLT = 4'b0111,
		ALU_NOR = 4'b1100
	} alu_ctrl_e;

endpackage

`default_nettype wire
